//--- list.f
cpu_pkg.sv
regfile.sv
alu.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --timing --assert --timescale 1ns/1ps
BUILD_ARGS = --binary -j 0
TOP        = tb_cpu
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) $(BUILD_ARGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_cpu.sv
`default_nettype none

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam int MAX_INST = 64;
    localparam int TRACE_TIMEOUT = 50;

    // instruction kinds for the program builder
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_SLT  = 2;
    localparam int K_SLTU = 3;
    localparam int K_NOR  = 4;
    localparam int K_AND  = 5;
    localparam int K_OR   = 6;
    localparam int K_XOR  = 7;
    localparam int K_SLL  = 8;
    localparam int K_SRL  = 9;
    localparam int K_SRA  = 10;
    localparam int K_ADDI = 11;
    localparam int K_LD   = 12;
    localparam int K_ST   = 13;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // one row per instruction with its expected trace
    logic [31:0] prog_inst [MAX_INST];
    logic        tab_we    [MAX_INST];
    logic [4:0]  tab_reg   [MAX_INST];
    logic [31:0] tab_val   [MAX_INST];
    logic [2:0]  tab_test  [MAX_INST];
    int          num_inst = 0;
    int          n_writes = 0;
    logic [2:0]  cur_test = 3'd0;

    // architectural state per the isa
    logic [31:0] model_reg [32];
    logic [31:0] model_mem [logic [31:0]];
    logic [31:0] exp_st_addr = 32'h0;
    logic [31:0] exp_st_data = 32'h0;

    // data sram contents and observed writes
    logic [31:0] dmem [logic [31:0]];
    int          store_count = 0;
    logic [31:0] st_addr_seen = 32'h0;
    logic [31:0] st_data_seen = 32'h0;

    int          checks [6];
    int          errors [6];
    int          events_seen = 0;
    logic        timed_out = 1'b0;

    cpu_top UUT (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #5 clk = ~clk;

    // pattern for unwritten data words uses every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (idx < 32'(num_inst)) begin
            return prog_inst[idx[5:0]];
        end
        // past the program an all-zero word matches no opcode
        return 32'h0;
    endfunction

    // instruction sram with one cycle read latency
    always @(posedge clk) begin
        inst_sram_rdata <= fetch_word(inst_sram_addr);
    end

    // data sram where a read sees the old word
    always @(posedge clk) begin
        data_sram_rdata <= dmem.exists(data_sram_addr) ? dmem[data_sram_addr]
                                                       : fill_word(data_sram_addr);
        if (data_sram_we) begin
            dmem[data_sram_addr] = data_sram_wdata;
            store_count <= store_count + 1;
            st_addr_seen <= data_sram_addr;
            st_data_seen <= data_sram_wdata;
        end
    end

    function automatic logic [16:0] rr_opcode(input int kind);
        case (kind)
            K_ADD:   return 17'h00020;
            K_SUB:   return 17'h00022;
            K_SLT:   return 17'h00024;
            K_SLTU:  return 17'h00025;
            K_NOR:   return 17'h00028;
            K_AND:   return 17'h00029;
            K_OR:    return 17'h0002a;
            K_XOR:   return 17'h0002b;
            K_SLL:   return 17'h00081;
            K_SRL:   return 17'h00089;
            default: return 17'h00091;
        endcase
    endfunction

    // isa results with the shift amount taken from b[4:0]
    function automatic logic [31:0] rr_result(input int kind, input logic [31:0] a,
                                              input logic [31:0] b);
        case (kind)
            K_ADD:   return a + b;
            K_SUB:   return a - b;
            K_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            K_NOR:   return ~(a | b);
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            K_SLL:   return a << b[4:0];
            K_SRL:   return a >> b[4:0];
            // logical shift with the vacated top bits taking the sign
            default: return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
        endcase
    endfunction

    task automatic push_entry(input logic [31:0] inst, input logic we, input logic [4:0] rd,
                              input logic [31:0] val);
        logic [5:0] row;
        row = num_inst[5:0];
        prog_inst[row] = inst;
        tab_we[row] = we;
        tab_reg[row] = rd;
        tab_val[row] = val;
        tab_test[row] = cur_test;
        if (we) begin
            model_reg[rd] = val;
            n_writes++;
        end
        num_inst++;
    endtask

    // 3r ops and shifts where rk carries ui5
    task automatic add_rr(input int kind, input logic [4:0] rd, input logic [4:0] rj,
                          input logic [4:0] rk);
        logic [31:0] b;
        b = (kind >= K_SLL) ? {27'h0, rk} : model_reg[rk];
        push_entry({rr_opcode(kind), rk, rj, rd}, 1'b1, rd, rr_result(kind, model_reg[rj], b));
    endtask

    task automatic add_ri12(input int kind, input logic [4:0] rd, input logic [4:0] rj,
                            input logic [11:0] si12);
        logic [31:0] addr;
        logic [9:0]  opc;
        addr = model_reg[rj] + {{20{si12[11]}}, si12};
        opc = (kind == K_ADDI) ? 10'h00a : (kind == K_LD) ? 10'h0a2 : 10'h0a6;
        if (kind == K_ST) begin
            exp_st_addr = addr;
            exp_st_data = model_reg[rd];
            model_mem[addr] = model_reg[rd];
            push_entry({opc, si12, rj, rd}, 1'b0, rd, 32'h0);
        end else if (kind == K_LD) begin
            push_entry({opc, si12, rj, rd}, 1'b1, rd,
                       model_mem.exists(addr) ? model_mem[addr] : fill_word(addr));
        end else begin
            push_entry({opc, si12, rj, rd}, 1'b1, rd, addr);
        end
    endtask

    task automatic add_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        push_entry({7'h0a, si20, rd}, 1'b1, rd, {si20, 12'h000});
    endtask

    task automatic build_program();
        logic [19:0] hi;
        logic [11:0] lo;
        int k;
        for (k = 0; k < 32; k++) begin
            model_reg[k[4:0]] = 32'h0;
        end
        // straight-line immediates
        cur_test = 3'd0;
        add_ri12(K_ADDI, 5'd1, 5'd0, 12'd5);
        add_ri12(K_ADDI, 5'd2, 5'd0, 12'hffd);
        add_ri12(K_ADDI, 5'd20, 5'd1, 12'h7ff);
        // random constants with the first one forced negative
        cur_test = 3'd1;
        for (k = 0; k < 3; k++) begin
            hi = 20'($urandom());
            lo = 12'($urandom());
            if (k == 0) begin
                hi[19] = 1'b1;
            end
            add_lu12i(5'(3 + k), hi);
            add_ri12(K_ADDI, 5'(3 + k), 5'(3 + k), lo);
        end
        // dependent chain with sources from ex, mem and wb
        cur_test = 3'd2;
        add_rr(K_ADD, 5'd6, 5'd3, 5'd4);
        add_rr(K_SUB, 5'd7, 5'd6, 5'd3);
        add_rr(K_SLT, 5'd8, 5'd7, 5'd6);
        add_rr(K_SLTU, 5'd9, 5'd2, 5'd7);
        add_rr(K_NOR, 5'd10, 5'd9, 5'd8);
        add_rr(K_AND, 5'd11, 5'd10, 5'd3);
        add_rr(K_OR, 5'd12, 5'd11, 5'd10);
        add_rr(K_XOR, 5'd13, 5'd12, 5'd10);
        add_rr(K_SLT, 5'd14, 5'd2, 5'd1);
        // r2 and r3 are negative and r20 is positive
        cur_test = 3'd3;
        add_rr(K_SLL, 5'd15, 5'd2, 5'($urandom_range(31, 0)));
        add_rr(K_SRL, 5'd16, 5'd3, 5'($urandom_range(31, 0)));
        add_rr(K_SRA, 5'd17, 5'd3, 5'($urandom_range(31, 0)));
        add_rr(K_SRA, 5'd18, 5'd20, 5'($urandom_range(31, 0)));
        add_rr(K_SRL, 5'd19, 5'd15, 5'($urandom_range(31, 0)));
        // the only store of the program
        cur_test = 3'd4;
        add_lu12i(5'd21, 20'h00010);
        add_ri12(K_ST, 5'd13, 5'd21, 12'h040);
        add_ri12(K_ADDI, 5'd22, 5'd0, 12'h001);
        add_ri12(K_LD, 5'd23, 5'd21, 12'h040);
        // consumers right behind loads
        cur_test = 3'd5;
        add_ri12(K_LD, 5'd24, 5'd21, 12'h040);
        add_rr(K_ADD, 5'd25, 5'd24, 5'd1);
        add_ri12(K_LD, 5'd26, 5'd21, 12'h044);
        add_rr(K_ADD, 5'd27, 5'd26, 5'd26);
        add_rr(K_SUB, 5'd28, 5'd27, 5'd24);
    endtask

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd0:    return "reset vector and pc sequence";
            3'd1:    return "lu12i.w and addi.w constants";
            3'd2:    return "dependent register-register ops";
            3'd3:    return "immediate shifts";
            3'd4:    return "store then load";
            default: return "load-use stall";
        endcase
    endfunction

    task automatic check(input logic [2:0] t, input string what, input logic [31:0] got,
                         input logic [31:0] exp);
        checks[t]++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors[t]++;
        end
    endtask

    // next retired register write, sampled mid-cycle
    task automatic wait_trace(input logic [2:0] t);
        int n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < TRACE_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = debug_wb_rf_we;
        end
        if (seen) begin
            events_seen++;
        end else begin
            $display("%0t ns: no trace event arrived within %0d cycles", $time, TRACE_TIMEOUT);
            errors[t]++;
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input logic [2:0] t);
        int n;
        int extra;
        extra = 0;
        if (t == 3'd4) begin
            check(t, "data sram write count", store_count, 32'd1);
            check(t, "store address", st_addr_seen, exp_st_addr);
            check(t, "store data", st_data_seen, exp_st_data);
        end
        if (t == 3'd5) begin
            // drain while nothing more may retire
            for (n = 0; n < 20; n++) begin
                @(negedge clk);
                if (debug_wb_rf_we) begin
                    extra++;
                end
            end
            check(t, "trace event count", events_seen + extra, n_writes);
        end
        $display("test %0d %s: %0d checks, %0d errors", t + 1, test_name(t), checks[t], errors[t]);
    endtask

    initial begin
        int i;
        int total_checks;
        int total_errors;
        logic [5:0] r;
        void'($urandom(82));
        build_program();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // first request out of reset
        @(negedge clk);
        check(3'd0, "first inst_sram_addr", inst_sram_addr, RESET_PC);
        for (i = 0; i < num_inst && !timed_out; i++) begin
            r = i[5:0];
            if (tab_we[r]) begin
                wait_trace(tab_test[r]);
                if (!timed_out) begin
                    check(tab_test[r], $sformatf("trace pc of row %0d", i), debug_wb_pc,
                          RESET_PC + 32'(4 * i));
                    check(tab_test[r], $sformatf("trace wnum of row %0d", i),
                          {27'h0, debug_wb_rf_wnum}, {27'h0, tab_reg[r]});
                    check(tab_test[r], $sformatf("trace wdata of row %0d", i),
                          debug_wb_rf_wdata, tab_val[r]);
                end
            end
            if (!timed_out && (i == num_inst - 1 || tab_test[r + 6'd1] != tab_test[r])) begin
                finish_test(tab_test[r]);
            end
        end
        total_checks = 0;
        total_errors = 0;
        for (i = 0; i < 6; i++) begin
            total_checks += checks[i[2:0]];
            total_errors += errors[i[2:0]];
        end
        $display("%0d checks, %0d errors", total_checks, total_errors);
        if (timed_out || total_errors != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_top.sv
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic              clk,
    input  logic              reset,
    // instruction sram
    output cpu_pkg::word_t    inst_sram_addr,
    input  cpu_pkg::word_t    inst_sram_rdata,
    // data sram
    output logic              data_sram_we,
    output cpu_pkg::word_t    data_sram_addr,
    output cpu_pkg::word_t    data_sram_wdata,
    input  cpu_pkg::word_t    data_sram_rdata,
    // write-back trace
    output cpu_pkg::word_t    debug_wb_pc,
    output logic              debug_wb_rf_we,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // if/id and the stall back to fetch
    logic     id_allowin;
    logic     id_valid;
    word_t    id_pc;
    word_t    id_inst;

    // id/ex
    logic     ex_valid;
    word_t    ex_pc;
    alu_op_e  ex_alu_op;
    word_t    ex_src1;
    word_t    ex_src2;
    word_t    ex_store_data;
    reg_idx_t ex_dest;
    logic     ex_gr_we;
    logic     ex_is_load;
    logic     ex_mem_we;
    word_t    ex_result;

    // ex/mem
    logic     mem_valid;
    word_t    mem_pc;
    word_t    mem_alu_result;
    reg_idx_t mem_dest;
    logic     mem_gr_we;
    logic     mem_is_load;
    word_t    mem_value;

    // wb into the regfile inside decode
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    // stage ports share the names of these nets
    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    // mem and wb share one module around the mem/wb register
    writeback_stage u_writeback (.*);

endmodule

`default_nettype wire

//--- writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  logic              clk,
    input  logic              reset,
    // ex/mem
    input  logic              mem_valid,
    input  cpu_pkg::word_t    mem_pc,
    input  cpu_pkg::word_t    mem_alu_result,
    input  cpu_pkg::reg_idx_t mem_dest,
    input  logic              mem_gr_we,
    input  logic              mem_is_load,
    input  cpu_pkg::word_t    data_sram_rdata,
    // mem result, also forwarded to decode
    output cpu_pkg::word_t    mem_value,
    // register write
    output logic              rf_we,
    output cpu_pkg::reg_idx_t rf_waddr,
    output cpu_pkg::word_t    rf_wdata,
    // trace
    output cpu_pkg::word_t    debug_wb_pc,
    output logic              debug_wb_rf_we,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic     wb_valid;
    word_t    wb_pc;
    word_t    wb_value;
    reg_idx_t wb_dest;
    logic     wb_gr_we;

    // sram word is valid one cycle after the ex address
    assign mem_value = mem_is_load ? data_sram_rdata : mem_alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc    <= mem_pc;
        wb_value <= mem_value;
        wb_dest  <= mem_dest;
        wb_gr_we <= mem_gr_we;
    end

    // stores and bubbles write nothing
    assign rf_we    = wb_valid && wb_gr_we;
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_value;

    // trace is the register write as seen by the regfile
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_value;

    // catches uninitialized registers or sram words leaking into state
    a_trace_known: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |-> !$isunknown(debug_wb_rf_wdata));

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    // id/ex
    input  logic              ex_valid,
    input  cpu_pkg::word_t    ex_pc,
    input  cpu_pkg::alu_op_e  ex_alu_op,
    input  cpu_pkg::word_t    ex_src1,
    input  cpu_pkg::word_t    ex_src2,
    input  cpu_pkg::word_t    ex_store_data,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  logic              ex_gr_we,
    input  logic              ex_is_load,
    input  logic              ex_mem_we,
    // forwarding back to decode
    output cpu_pkg::word_t    ex_result,
    // data sram request
    output logic              data_sram_we,
    output cpu_pkg::word_t    data_sram_addr,
    output cpu_pkg::word_t    data_sram_wdata,
    // ex/mem
    output logic              mem_valid,
    output cpu_pkg::word_t    mem_pc,
    output cpu_pkg::word_t    mem_alu_result,
    output cpu_pkg::reg_idx_t mem_dest,
    output logic              mem_gr_we,
    output logic              mem_is_load
);
    import cpu_pkg::*;

    // one result feeds forwarding, sram address and ex/mem
    word_t alu_out;

    alu u_alu (
        .alu_op (ex_alu_op),
        .src1   (ex_src1),
        .src2   (ex_src2),
        .result (alu_out)
    );

    assign ex_result = alu_out;

    // load address and store both issue here
    // load data then shows up while the load is in mem
    assign data_sram_addr  = alu_out;
    assign data_sram_wdata = ex_store_data;
    assign data_sram_we    = ex_valid && ex_mem_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc         <= ex_pc;
        mem_alu_result <= alu_out;
        mem_dest       <= ex_dest;
        mem_gr_we      <= ex_gr_we;
        mem_is_load    <= ex_is_load;
    end

    // decode never flags one instruction as both load and store
    a_no_store_on_load: assert property (@(posedge clk) disable iff (reset)
        !(data_sram_we && ex_is_load));

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    // if/id
    input  logic              id_valid,
    input  cpu_pkg::word_t    id_pc,
    input  cpu_pkg::word_t    id_inst,
    output logic              id_allowin,
    // forwarding from ex and mem
    input  cpu_pkg::word_t    ex_result,
    input  logic              mem_valid,
    input  cpu_pkg::reg_idx_t mem_dest,
    input  logic              mem_gr_we,
    input  cpu_pkg::word_t    mem_value,
    // register write from wb
    input  logic              rf_we,
    input  cpu_pkg::reg_idx_t rf_waddr,
    input  cpu_pkg::word_t    rf_wdata,
    // id/ex
    output logic              ex_valid,
    output cpu_pkg::word_t    ex_pc,
    output cpu_pkg::alu_op_e  ex_alu_op,
    output cpu_pkg::word_t    ex_src1,
    output cpu_pkg::word_t    ex_src2,
    output cpu_pkg::word_t    ex_store_data,
    output cpu_pkg::reg_idx_t ex_dest,
    output logic              ex_gr_we,
    output logic              ex_is_load,
    output logic              ex_mem_we
);
    import cpu_pkg::*;

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    reg_idx_t raddr2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    rj_value;
    word_t    rkd_value;
    word_t    imm;
    alu_op_e  alu_op;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_ld_w, inst_st_w, inst_lu12i_w;
    logic is_rr;
    logic is_shift;
    logic src2_is_imm;
    logic use_rj;
    logic use_r2;
    logic gr_we;
    logic load_hazard;

    // la32r register fields
    assign rd = id_inst[4:0];
    assign rj = id_inst[9:5];
    assign rk = id_inst[14:10];

    assign inst_add_w   = id_inst[31:15] == OPC_ADD_W;
    assign inst_sub_w   = id_inst[31:15] == OPC_SUB_W;
    assign inst_slt     = id_inst[31:15] == OPC_SLT;
    assign inst_sltu    = id_inst[31:15] == OPC_SLTU;
    assign inst_nor     = id_inst[31:15] == OPC_NOR;
    assign inst_and     = id_inst[31:15] == OPC_AND;
    assign inst_or      = id_inst[31:15] == OPC_OR;
    assign inst_xor     = id_inst[31:15] == OPC_XOR;
    assign inst_slli_w  = id_inst[31:15] == OPC_SLLI_W;
    assign inst_srli_w  = id_inst[31:15] == OPC_SRLI_W;
    assign inst_srai_w  = id_inst[31:15] == OPC_SRAI_W;
    assign inst_addi_w  = id_inst[31:22] == OPC_ADDI_W;
    assign inst_ld_w    = id_inst[31:22] == OPC_LD_W;
    assign inst_st_w    = id_inst[31:22] == OPC_ST_W;
    assign inst_lu12i_w = id_inst[31:25] == OPC_LU12I_W;

    assign is_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu |
                   inst_nor | inst_and | inst_or | inst_xor;
    assign is_shift = inst_slli_w | inst_srli_w | inst_srai_w;

    // which sources are really read, for the stall check
    assign use_rj = is_rr | is_shift | inst_addi_w | inst_ld_w | inst_st_w;
    assign use_r2 = is_rr | inst_st_w;
    assign src2_is_imm = is_shift | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w;
    assign gr_we = is_rr | is_shift | inst_addi_w | inst_ld_w | inst_lu12i_w;

    // store data comes from rd
    assign raddr2 = inst_st_w ? rd : rk;

    // si20 already placed for lu12i, ui5 sits in the low bits of si12
    assign imm = inst_lu12i_w ? {id_inst[24:5], 12'b0}
                              : {{20{id_inst[21]}}, id_inst[21:10]};

    always_comb begin
        case (1'b1)
            inst_sub_w:   alu_op = ALU_SUB;
            inst_slt:     alu_op = ALU_SLT;
            inst_sltu:    alu_op = ALU_SLTU;
            inst_and:     alu_op = ALU_AND;
            inst_nor:     alu_op = ALU_NOR;
            inst_or:      alu_op = ALU_OR;
            inst_xor:     alu_op = ALU_XOR;
            inst_slli_w:  alu_op = ALU_SLL;
            inst_srli_w:  alu_op = ALU_SRL;
            inst_srai_w:  alu_op = ALU_SRA;
            inst_lu12i_w: alu_op = ALU_LUI;
            // add.w, addi.w and address generation
            default:      alu_op = ALU_ADD;
        endcase
    end

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // youngest producer wins, a load in ex has no value yet
    // wb needs no path here since the regfile is write-first
    function automatic word_t forward(reg_idx_t src, word_t rf_value);
        if (src != '0 && ex_valid && ex_gr_we && !ex_is_load && ex_dest == src) begin
            return ex_result;
        end
        if (src != '0 && mem_valid && mem_gr_we && mem_dest == src) begin
            return mem_value;
        end
        return rf_value;
    endfunction

    always_comb begin
        rj_value  = forward(rj, rf_rdata1);
        rkd_value = forward(raddr2, rf_rdata2);
    end

    // load data only reaches mem next cycle
    assign load_hazard = ex_valid && ex_is_load && ex_dest != '0 &&
                         ((use_rj && rj == ex_dest) || (use_r2 && raddr2 == ex_dest));
    assign id_allowin = !(id_valid && load_hazard);

    // ex always advances, a stall leaves a bubble behind
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid && id_allowin;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= id_pc;
        ex_alu_op     <= alu_op;
        ex_src1       <= rj_value;
        ex_src2       <= src2_is_imm ? imm : rkd_value;
        ex_store_data <= rkd_value;
        ex_dest       <= rd;
        ex_gr_we      <= gr_we;
        ex_is_load    <= inst_ld_w;
        ex_mem_we     <= inst_st_w;
    end

    // stall only behind a load in ex, and the bubble clears it next cycle
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        !id_allowin |-> (ex_valid && ex_is_load) ##1 id_allowin);

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           id_allowin,
    input  cpu_pkg::word_t inst_sram_rdata,
    output cpu_pkg::word_t inst_sram_addr,
    output logic           id_valid,
    output cpu_pkg::word_t id_pc,
    output cpu_pkg::word_t id_inst
);
    import cpu_pkg::*;

    // pc of the word now arriving on inst_sram_rdata
    word_t pc;
    // arriving word belongs to a real fetch
    logic  if_valid;
    word_t seq_pc;

    // no branches, so the pc only ever steps by 4
    // first request after reset goes out with RESET_PC itself
    assign seq_pc = if_valid ? pc + 32'd4 : pc;

    // stall re-reads the current pc so rdata is still there next cycle
    assign inst_sram_addr = id_allowin ? seq_pc : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else begin
            pc       <= inst_sram_addr;
            if_valid <= 1'b1;
        end
    end

    // if/id register, held while decode is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_allowin) begin
            id_pc   <= pc;
            id_inst <= inst_sram_rdata;
        end
    end

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e alu_op,
    input  cpu_pkg::word_t   src1,
    input  cpu_pkg::word_t   src2,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    // shift amount is the low 5 bits of src2
    logic [4:0] sa;

    assign sa = src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << sa;
            ALU_SRL:  result = src1 >> sa;
            // sign bit fills from the left
            ALU_SRA:  result = word_t'($signed(src1) >>> sa);
            // decode already shifted si20 into place
            ALU_LUI:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- regfile.sv
`default_nettype none

module regfile (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::word_t    wdata
);
    import cpu_pkg::*;

    // r0 slot exists but is never written or read
    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // one read port, write-first when wb hits the same register
    function automatic word_t read_port(reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // datapath word, also used for addresses
    typedef logic [31:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    localparam int NUM_REGS = 32;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // 3r and shift-immediate forms, matched on inst[31:15]
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;

    // 2ri12 forms, matched on inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_LD_W   = 10'h0a2;
    localparam logic [9:0] OPC_ST_W   = 10'h0a6;

    // 1ri20 form, matched on inst[31:25]
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

endpackage

`default_nettype wire
